//--- verilog/ft_master_pkg.sv
/*
  ft600 style fifo master, shared constants and stream types
*/
package ft_master_pkg;

  // --------------------------------------------------
  // bus geometry
  // --------------------------------------------------
  // endpoint channels on the bridge
  localparam int CNT_CHANNELS = 4;
  // data lanes and byte enables per word
  localparam int WIDTH_DATA   = 32;
  localparam int CNT_BE       = 4;
  // channel index width
  localparam int CH_W         = 2;
  // burst length and fill count width, depth up to 32
  localparam int LEN_W        = 6;

  // --------------------------------------------------
  // stream payloads
  // --------------------------------------------------
  // one bus word with its byte enables
  typedef struct packed {
    logic [WIDTH_DATA-1:0] data;
    logic [CNT_BE-1:0]     be;
  } ft_word_t;

  // read moves chip to master, write master to chip
  typedef enum logic {
    DIR_READ  = 1'b0,
    DIR_WRITE = 1'b1
  } ft_dir_e;

  // burst command as issued on the bus
  typedef struct packed {
    logic [CH_W-1:0]  ch;
    ft_dir_e          dir;
    logic [LEN_W-1:0] len;
  } ft_cmd_t;

  // one flag per channel
  typedef logic [CNT_CHANNELS-1:0] ch_vec_t;

endpackage

//--- verilog/ep_fifo.sv
/*
  endpoint buffer, first-word-fall-through fifo with fill count
*/
module ep_fifo #(
  parameter int EP_DEPTH = 16
) (
  input  logic                            i_fifo_clk,
  input  logic                            i_rst,
  input  logic                            i_push,
  input  ft_master_pkg::ft_word_t         i_push_word,
  input  logic                            i_pop,
  output ft_master_pkg::ft_word_t         o_head,
  output logic [ft_master_pkg::LEN_W-1:0] o_fill
);
  import ft_master_pkg::*;

  localparam int PTR_W = (EP_DEPTH > 1) ? $clog2(EP_DEPTH) : 1;

  // word storage
  ft_word_t         mem [EP_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             do_push;
  logic             do_pop;

  // pointer step with wrap, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_step(input logic [PTR_W-1:0] p);
    if (p == PTR_W'(EP_DEPTH - 1))
      ptr_step = '0;
    else
      ptr_step = p + 1'b1;
  endfunction

  // guard against overflow and underflow
  assign do_push = i_push && (o_fill < LEN_W'(EP_DEPTH));
  assign do_pop  = i_pop && (o_fill != '0);

  // head falls through, valid while fill is non-zero
  assign o_head = mem[rd_ptr];

  always_ff @(posedge i_fifo_clk)
  begin
    if (do_push)
      mem[wr_ptr] <= i_push_word;
  end

  // --------------------------------------------------
  // pointers and fill count
  // --------------------------------------------------
  always_ff @(posedge i_fifo_clk)
  begin
    if (i_rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      o_fill <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= ptr_step(wr_ptr);
      if (do_pop)
        rd_ptr <= ptr_step(rd_ptr);
      // simultaneous push and pop keeps the count
      case ({do_push, do_pop})
        2'b10:   o_fill <= o_fill + 1'b1;
        2'b01:   o_fill <= o_fill - 1'b1;
        default: o_fill <= o_fill;
      endcase
    end
  end

endmodule

//--- verilog/ep_buffer_bank.sv
/*
  endpoint buffer bank, one fifo per channel
  push and pop go to the selected channel, its head is muxed out
*/
module ep_buffer_bank #(
  parameter int EP_DEPTH = 16
) (
  input  logic                           i_fifo_clk,
  input  logic                           i_rst,
  input  logic [ft_master_pkg::CH_W-1:0] i_sel_ch,
  input  logic                           i_push,
  input  ft_master_pkg::ft_word_t        i_push_word,
  input  logic                           i_pop,
  output ft_master_pkg::ft_word_t        o_head,
  output logic [ft_master_pkg::CNT_CHANNELS-1:0][ft_master_pkg::LEN_W-1:0] o_fill_all,
  output ft_master_pkg::ch_vec_t         o_ep_empty
);
  import ft_master_pkg::*;

  // per channel strobes and heads
  ch_vec_t  push_vec;
  ch_vec_t  pop_vec;
  ft_word_t head_all [CNT_CHANNELS];

  // --------------------------------------------------
  // channel buffers
  // --------------------------------------------------
  genvar g;
  generate
    for (g = 0; g < CNT_CHANNELS; g++)
    begin : g_ep
      // only the selected channel sees the strobes
      assign push_vec[g] = i_push && (i_sel_ch == CH_W'(g));
      assign pop_vec[g]  = i_pop && (i_sel_ch == CH_W'(g));

      ep_fifo #(
        .EP_DEPTH (EP_DEPTH)
      ) u_ep_fifo (
        .i_fifo_clk  (i_fifo_clk),
        .i_rst       (i_rst),
        .i_push      (push_vec[g]),
        .i_push_word (i_push_word),
        .i_pop       (pop_vec[g]),
        .o_head      (head_all[g]),
        .o_fill      (o_fill_all[g])
      );

      // empty flag for the status leds
      assign o_ep_empty[g] = (o_fill_all[g] == '0);
    end
  endgenerate

  // selected head toward the tx stream
  assign o_head = head_all[i_sel_ch];

endmodule

//--- verilog/ft_arbiter.sv
/*
  round-robin arbiter, picks channel, direction and burst length
  from buffer fill levels and slave status flags
*/
module ft_arbiter #(
  parameter int EP_DEPTH  = 16,
  parameter int BURST_MAX = 8
) (
  input  logic                    i_fifo_clk,
  input  logic                    i_rst,
  input  logic [ft_master_pkg::CNT_CHANNELS-1:0][ft_master_pkg::LEN_W-1:0] i_fill_all,
  input  ft_master_pkg::ch_vec_t  i_slv_rx_avail,
  input  ft_master_pkg::ch_vec_t  i_slv_tx_room,
  output ft_master_pkg::ft_cmd_t  o_req,
  output logic                    o_req_valid,
  input  logic                    i_req_ready
);
  import ft_master_pkg::*;

  logic [CH_W-1:0]                    rr_ptr;
  logic [CH_W-1:0]                    idx;
  ch_vec_t                            wr_elig;
  ch_vec_t                            rd_elig;
  logic [CNT_CHANNELS-1:0][LEN_W-1:0] wr_len;
  logic [CNT_CHANNELS-1:0][LEN_W-1:0] rd_len;
  logic                               found;
  logic                               grant;
  ft_cmd_t                            pick;

  function automatic logic [LEN_W-1:0] clip_len(input logic [LEN_W-1:0] n);
    if (n > LEN_W'(BURST_MAX))
      clip_len = LEN_W'(BURST_MAX);
    else
      clip_len = n;
  endfunction

  // --------------------------------------------------
  // eligibility and burst lengths per channel
  // --------------------------------------------------
  always_comb
  begin
    for (int c = 0; c < CNT_CHANNELS; c++)
    begin
      // write drains what is buffered
      wr_elig[c] = (i_fill_all[c] != '0) && i_slv_tx_room[c];
      wr_len[c]  = clip_len(i_fill_all[c]);
      // read fills the free space
      rd_elig[c] = (i_fill_all[c] < LEN_W'(EP_DEPTH)) && i_slv_rx_avail[c];
      rd_len[c]  = clip_len(LEN_W'(EP_DEPTH) - i_fill_all[c]);
    end
  end

  // search starts at rr_ptr, first eligible channel wins
  always_comb
  begin
    found = 1'b0;
    pick  = '0;
    idx   = '0;
    for (int i = 0; i < CNT_CHANNELS; i++)
    begin
      idx = CH_W'((int'(rr_ptr) + i) % CNT_CHANNELS);
      if (!found && (wr_elig[idx] || rd_elig[idx]))
      begin
        found   = 1'b1;
        pick.ch = idx;
        // write wins over read within a channel
        if (wr_elig[idx])
        begin
          pick.dir = DIR_WRITE;
          pick.len = wr_len[idx];
        end
        else
        begin
          pick.dir = DIR_READ;
          pick.len = rd_len[idx];
        end
      end
    end
  end

  // evaluate only with sequencer idle, so fill levels are settled
  assign grant = !o_req_valid && i_req_ready && found;

  // --------------------------------------------------
  // registered request
  // --------------------------------------------------
  always_ff @(posedge i_fifo_clk)
  begin
    if (i_rst)
    begin
      o_req_valid <= 1'b0;
      rr_ptr      <= '0;
    end
    else if (o_req_valid)
    begin
      // hold until taken
      if (i_req_ready)
        o_req_valid <= 1'b0;
    end
    else if (grant)
    begin
      o_req_valid <= 1'b1;
      // next search starts one past the granted channel
      rr_ptr      <= CH_W'((int'(pick.ch) + 1) % CNT_CHANNELS);
    end
  end

  always_ff @(posedge i_fifo_clk)
  begin
    if (grant)
      o_req <= pick;
  end

endmodule

//--- verilog/ft_bus_fsm.sv
/*
  bus sequencer, issues the burst command and moves the words
  between the rx/tx streams and the endpoint bank
*/
module ft_bus_fsm (
  input  logic                           i_fifo_clk,
  input  logic                           i_rst,
  input  ft_master_pkg::ft_cmd_t         i_req,
  input  logic                           i_req_valid,
  output logic                           o_req_ready,
  output ft_master_pkg::ft_cmd_t         o_cmd,
  output logic                           o_cmd_valid,
  input  logic                           i_cmd_ready,
  input  ft_master_pkg::ft_word_t        i_rx,
  input  logic                           i_rx_valid,
  output logic                           o_rx_ready,
  output ft_master_pkg::ft_word_t        o_tx,
  output logic                           o_tx_valid,
  input  logic                           i_tx_ready,
  output logic [ft_master_pkg::CH_W-1:0] o_sel_ch,
  output logic                           o_push,
  output ft_master_pkg::ft_word_t        o_push_word,
  output logic                           o_pop,
  input  ft_master_pkg::ft_word_t        i_head
);
  import ft_master_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    CMD,
    READ,
    WRITE
  } state_e;

  state_e           state;
  // command latched for the whole burst
  ft_cmd_t          cmd;
  // words left in the burst
  logic [LEN_W-1:0] remain;
  logic             xfer;

  // --------------------------------------------------
  // handshakes decoded from state
  // --------------------------------------------------
  assign o_req_ready = (state == IDLE);
  assign o_cmd       = cmd;
  assign o_cmd_valid = (state == CMD);
  assign o_rx_ready  = (state == READ);
  assign o_tx_valid  = (state == WRITE);
  assign o_tx        = i_head;

  // bank side follows the stream transfers
  assign o_sel_ch    = cmd.ch;
  assign o_push      = (state == READ) && i_rx_valid;
  assign o_push_word = i_rx;
  assign o_pop       = (state == WRITE) && i_tx_ready;

  // one data word moved this cycle
  assign xfer = o_push || o_pop;

  always_ff @(posedge i_fifo_clk)
  begin
    if (i_rst)
    begin
      state  <= IDLE;
      remain <= '0;
    end
    else
    begin
      case (state)
        IDLE:
          if (i_req_valid)
          begin
            remain <= i_req.len;
            state  <= CMD;
          end
        CMD:
          if (i_cmd_ready)
            state <= (cmd.dir == DIR_READ) ? READ : WRITE;
        default:
          if (xfer)
          begin
            remain <= remain - 1'b1;
            // last word ends the burst
            if (remain == LEN_W'(1))
              state <= IDLE;
          end
      endcase
    end
  end

  always_ff @(posedge i_fifo_clk)
  begin
    if ((state == IDLE) && i_req_valid)
      cmd <= i_req;
  end

endmodule

//--- verilog/ft_master_top.sv
/*
  ft600 style multi-channel fifo master, loopback through the endpoint buffers
*/
module ft_master_top #(
  parameter int EP_DEPTH  = 16,
  parameter int BURST_MAX = 8
) (
  input  logic                    i_fifo_clk,
  input  logic                    i_rst,
  // command stream
  output ft_master_pkg::ft_cmd_t  o_cmd,
  output logic                    o_cmd_valid,
  input  logic                    i_cmd_ready,
  // receive stream
  input  ft_master_pkg::ft_word_t i_rx,
  input  logic                    i_rx_valid,
  output logic                    o_rx_ready,
  // transmit stream
  output ft_master_pkg::ft_word_t o_tx,
  output logic                    o_tx_valid,
  input  logic                    i_tx_ready,
  // slave status and buffer flags
  input  ft_master_pkg::ch_vec_t  i_slv_rx_avail,
  input  ft_master_pkg::ch_vec_t  i_slv_tx_room,
  output ft_master_pkg::ch_vec_t  o_ep_empty
);
  import ft_master_pkg::*;

  // --------------------------------------------------
  // internal wiring
  // --------------------------------------------------
  logic [CNT_CHANNELS-1:0][LEN_W-1:0] fill_all;
  ft_cmd_t                            arb_req;
  logic                               arb_valid;
  logic                               arb_ready;
  logic [CH_W-1:0]                    sel_ch;
  logic                               push;
  ft_word_t                           push_word;
  logic                               pop;
  ft_word_t                           head;

  ep_buffer_bank #(
    .EP_DEPTH (EP_DEPTH)
  ) u_bank (
    .i_fifo_clk  (i_fifo_clk),
    .i_rst       (i_rst),
    .i_sel_ch    (sel_ch),
    .i_push      (push),
    .i_push_word (push_word),
    .i_pop       (pop),
    .o_head      (head),
    .o_fill_all  (fill_all),
    .o_ep_empty  (o_ep_empty)
  );

  ft_arbiter #(
    .EP_DEPTH  (EP_DEPTH),
    .BURST_MAX (BURST_MAX)
  ) u_arb (
    .i_fifo_clk     (i_fifo_clk),
    .i_rst          (i_rst),
    .i_fill_all     (fill_all),
    .i_slv_rx_avail (i_slv_rx_avail),
    .i_slv_tx_room  (i_slv_tx_room),
    .o_req          (arb_req),
    .o_req_valid    (arb_valid),
    .i_req_ready    (arb_ready)
  );

  ft_bus_fsm u_fsm (
    .i_fifo_clk  (i_fifo_clk),
    .i_rst       (i_rst),
    .i_req       (arb_req),
    .i_req_valid (arb_valid),
    .o_req_ready (arb_ready),
    .o_cmd       (o_cmd),
    .o_cmd_valid (o_cmd_valid),
    .i_cmd_ready (i_cmd_ready),
    .i_rx        (i_rx),
    .i_rx_valid  (i_rx_valid),
    .o_rx_ready  (o_rx_ready),
    .o_tx        (o_tx),
    .o_tx_valid  (o_tx_valid),
    .i_tx_ready  (i_tx_ready),
    .o_sel_ch    (sel_ch),
    .o_push      (push),
    .o_push_word (push_word),
    .o_pop       (pop),
    .i_head      (head)
  );

endmodule

//--- test/tb_ft_master.sv
/*
  testbench for the ft600 style fifo master
  slave model answers commands and checks the looped back words
*/
module tb_ft_master;
  timeunit 1ns;
  timeprecision 1ps;
  import ft_master_pkg::*;

  localparam int EP_DEPTH  = 12;
  localparam int BURST_MAX = 8;
  localparam int N_TESTS   = 6;
  // idle cycles allowed while waiting on a handshake
  localparam int WAIT_MAX  = 200;

  logic     fifo_clk;
  logic     i_rst;
  ft_cmd_t  o_cmd;
  logic     o_cmd_valid;
  logic     i_cmd_ready;
  ft_word_t i_rx;
  logic     i_rx_valid;
  logic     o_rx_ready;
  ft_word_t o_tx;
  logic     o_tx_valid;
  logic     i_tx_ready;
  ch_vec_t  i_slv_rx_avail;
  ch_vec_t  i_slv_tx_room;
  ch_vec_t  o_ep_empty;

  int       errors;
  int       seed;
  // words sent by the slave, per channel, oldest first
  ft_word_t exp_q [CNT_CHANNELS][$];

  ft_master_top #(
    .EP_DEPTH  (EP_DEPTH),
    .BURST_MAX (BURST_MAX)
  ) dut (
    .i_fifo_clk     (fifo_clk),
    .i_rst          (i_rst),
    .o_cmd          (o_cmd),
    .o_cmd_valid    (o_cmd_valid),
    .i_cmd_ready    (i_cmd_ready),
    .i_rx           (i_rx),
    .i_rx_valid     (i_rx_valid),
    .o_rx_ready     (o_rx_ready),
    .o_tx           (o_tx),
    .o_tx_valid     (o_tx_valid),
    .i_tx_ready     (i_tx_ready),
    .i_slv_rx_avail (i_slv_rx_avail),
    .i_slv_tx_room  (i_slv_tx_room),
    .o_ep_empty     (o_ep_empty)
  );

  // 40 ns clock
  always #20 fifo_clk = ~fifo_clk;

  // --------------------------------------------------
  // slave model
  // --------------------------------------------------
  // true about two times in three
  function automatic bit go_now();
    go_now = (($random(seed) % 3) != 0);
  endfunction

  task automatic reset_dut();
    i_rst = 1'b1;
    repeat (5) @(negedge fifo_clk);
    i_rst = 1'b0;
    for (int c = 0; c < CNT_CHANNELS; c++)
      exp_q[c].delete();
  endtask

  // wait for a command, check it, accept it
  task automatic expect_cmd(input int ch, input ft_dir_e dir, input int len, input bit stall);
    int      waited;
    bit      seen;
    bit      done;
    ft_cmd_t first;
    waited = 0;
    seen   = 1'b0;
    done   = 1'b0;
    while (!done)
    begin
      @(negedge fifo_clk);
      i_cmd_ready = 1'b0;
      if (o_cmd_valid)
      begin
        if (!seen)
        begin
          first = o_cmd;
          if (o_cmd.ch !== CH_W'(ch))
          begin
            $display("[FAIL] o_cmd.ch: got %h expected %h", o_cmd.ch, CH_W'(ch));
            errors++;
          end
          if (o_cmd.dir !== dir)
          begin
            $display("[FAIL] o_cmd.dir: got %h expected %h", o_cmd.dir, dir);
            errors++;
          end
          if (o_cmd.len !== LEN_W'(len))
          begin
            $display("[FAIL] o_cmd.len: got %h expected %h", o_cmd.len, LEN_W'(len));
            errors++;
          end
        end
        else if (o_cmd !== first)
        begin
          $display("[FAIL] o_cmd: got %h expected %h", o_cmd, first);
          errors++;
        end
        seen = 1'b1;
        if (!stall || go_now())
        begin
          i_cmd_ready = 1'b1;
          done        = 1'b1;
        end
      end
      else if (seen)
      begin
        $display("command on channel %0d withdrawn before it was accepted", ch);
        errors++;
        done = 1'b1;
      end
      else
      begin
        waited++;
        if (waited > WAIT_MAX)
        begin
          $display("no command appeared for channel %0d", ch);
          errors++;
          done = 1'b1;
        end
      end
    end
    @(negedge fifo_clk);
    i_cmd_ready = 1'b0;
  endtask

  // send n fresh words and remember them
  task automatic supply_rx(input int ch, input int n, input bit stall);
    int k;
    int waited;
    bit moving;
    k      = 0;
    waited = 0;
    moving = 1'b0;
    while (k < n)
    begin
      @(negedge fifo_clk);
      // word went out at the last edge
      if (moving)
        i_rx_valid = 1'b0;
      moving = 1'b0;
      if (!i_rx_valid && (!stall || go_now()))
      begin
        i_rx.data  = $random(seed);
        i_rx.be    = CNT_BE'($random(seed));
        i_rx_valid = 1'b1;
      end
      if (i_rx_valid && o_rx_ready)
      begin
        exp_q[ch].push_back(i_rx);
        moving = 1'b1;
        k++;
      end
      else
      begin
        waited++;
        if (waited > WAIT_MAX)
        begin
          $display("receive stream stalled on channel %0d after %0d words", ch, k);
          errors++;
          break;
        end
      end
    end
    @(negedge fifo_clk);
    i_rx_valid = 1'b0;
  endtask

  // take n words and compare with what was sent
  task automatic drain_tx(input int ch, input int n, input bit stall);
    int       k;
    int       waited;
    ft_word_t want;
    k      = 0;
    waited = 0;
    while (k < n)
    begin
      @(negedge fifo_clk);
      i_tx_ready = !stall || go_now();
      if (o_tx_valid && i_tx_ready)
      begin
        k++;
        if (exp_q[ch].size() == 0)
        begin
          $display("extra word on channel %0d with nothing left to compare", ch);
          errors++;
        end
        else
        begin
          want = exp_q[ch].pop_front();
          if (o_tx.data !== want.data)
          begin
            $display("[FAIL] o_tx.data: got %h expected %h", o_tx.data, want.data);
            errors++;
          end
          if (o_tx.be !== want.be)
          begin
            $display("[FAIL] o_tx.be: got %h expected %h", o_tx.be, want.be);
            errors++;
          end
        end
      end
      else
      begin
        waited++;
        if (waited > WAIT_MAX)
        begin
          $display("transmit stream stalled on channel %0d after %0d words", ch, k);
          errors++;
          break;
        end
      end
    end
    @(negedge fifo_clk);
    i_tx_ready = 1'b0;
  endtask

  // nothing may move for a while
  task automatic check_quiet(input int cycles);
    repeat (cycles)
    begin
      @(negedge fifo_clk);
      if (o_cmd_valid || o_tx_valid || o_rx_ready)
      begin
        $display("bus activity where none was expected, command %h", o_cmd);
        errors++;
        break;
      end
    end
  endtask

  task automatic check_drained();
    for (int c = 0; c < CNT_CHANNELS; c++)
    begin
      if (exp_q[c].size() != 0)
      begin
        $display("%0d words on channel %0d never came back", exp_q[c].size(), c);
        errors++;
      end
    end
    if (o_ep_empty !== '1)
    begin
      $display("[FAIL] o_ep_empty: got %h expected %h", o_ep_empty, ch_vec_t'('1));
      errors++;
    end
  endtask

  // --------------------------------------------------
  // directed tests
  // --------------------------------------------------
  task automatic test_reset();
    reset_dut();
    if (o_cmd_valid !== 1'b0)
    begin
      $display("[FAIL] o_cmd_valid: got %h expected %h", o_cmd_valid, 1'b0);
      errors++;
    end
    if (o_rx_ready !== 1'b0)
    begin
      $display("[FAIL] o_rx_ready: got %h expected %h", o_rx_ready, 1'b0);
      errors++;
    end
    if (o_tx_valid !== 1'b0)
    begin
      $display("[FAIL] o_tx_valid: got %h expected %h", o_tx_valid, 1'b0);
      errors++;
    end
    check_drained();
  endtask

  task automatic test_loopback();
    i_slv_rx_avail[2] = 1'b1;
    expect_cmd(2, DIR_READ, 8, 1'b0);
    // slave held exactly one burst
    i_slv_rx_avail[2] = 1'b0;
    supply_rx(2, 8, 1'b0);
    if (o_ep_empty[2] !== 1'b0)
    begin
      $display("[FAIL] o_ep_empty[2]: got %h expected %h", o_ep_empty[2], 1'b0);
      errors++;
    end
    i_slv_tx_room[2] = 1'b1;
    expect_cmd(2, DIR_WRITE, 8, 1'b0);
    i_slv_tx_room[2] = 1'b0;
    drain_tx(2, 8, 1'b0);
    check_drained();
  endtask

  task automatic test_free_space();
    i_slv_rx_avail[1] = 1'b1;
    expect_cmd(1, DIR_READ, 8, 1'b0);
    supply_rx(1, 8, 1'b0);
    // 12 deep, so 4 places left
    expect_cmd(1, DIR_READ, 4, 1'b0);
    supply_rx(1, 4, 1'b0);
    // full buffer, avail still set
    check_quiet(30);
    i_slv_rx_avail[1] = 1'b0;
    i_slv_tx_room[1]  = 1'b1;
    expect_cmd(1, DIR_WRITE, 8, 1'b0);
    drain_tx(1, 8, 1'b0);
    expect_cmd(1, DIR_WRITE, 4, 1'b0);
    drain_tx(1, 4, 1'b0);
    i_slv_tx_room[1] = 1'b0;
    check_drained();
  endtask

  task automatic test_round_robin();
    // search restarts at channel 0
    reset_dut();
    i_slv_rx_avail = '1;
    for (int c = 0; c < CNT_CHANNELS; c++)
    begin
      expect_cmd(c, DIR_READ, BURST_MAX, 1'b0);
      if (c == CNT_CHANNELS - 1)
        i_slv_rx_avail = '0;
      supply_rx(c, BURST_MAX, 1'b0);
    end
    i_slv_tx_room = '1;
    for (int c = 0; c < CNT_CHANNELS; c++)
    begin
      expect_cmd(c, DIR_WRITE, BURST_MAX, 1'b0);
      if (c == CNT_CHANNELS - 1)
        i_slv_tx_room = '0;
      drain_tx(c, BURST_MAX, 1'b0);
    end
    check_drained();
  endtask

  task automatic test_write_over_read();
    i_slv_rx_avail[3] = 1'b1;
    expect_cmd(3, DIR_READ, 8, 1'b0);
    i_slv_rx_avail[3] = 1'b0;
    supply_rx(3, 8, 1'b0);
    // 8 of 12 used, both directions possible
    i_slv_rx_avail[3] = 1'b1;
    i_slv_tx_room[3]  = 1'b1;
    expect_cmd(3, DIR_WRITE, 8, 1'b0);
    i_slv_rx_avail[3] = 1'b0;
    i_slv_tx_room[3]  = 1'b0;
    drain_tx(3, 8, 1'b0);
    check_drained();
  endtask

  task automatic test_backpressure();
    i_slv_rx_avail[0] = 1'b1;
    expect_cmd(0, DIR_READ, 8, 1'b1);
    supply_rx(0, 8, 1'b1);
    expect_cmd(0, DIR_READ, 4, 1'b1);
    i_slv_rx_avail[0] = 1'b0;
    supply_rx(0, 4, 1'b1);
    i_slv_tx_room[0] = 1'b1;
    expect_cmd(0, DIR_WRITE, 8, 1'b1);
    drain_tx(0, 8, 1'b1);
    expect_cmd(0, DIR_WRITE, 4, 1'b1);
    i_slv_tx_room[0] = 1'b0;
    drain_tx(0, 4, 1'b1);
    // no duplicate word or command afterwards
    check_quiet(20);
    check_drained();
  endtask

  initial
  begin
    fifo_clk       = 1'b0;
    i_rst          = 1'b1;
    i_cmd_ready    = 1'b0;
    i_rx           = '0;
    i_rx_valid     = 1'b0;
    i_tx_ready     = 1'b0;
    i_slv_rx_avail = '0;
    i_slv_tx_room  = '0;
    errors         = 0;
    seed           = 2;
    test_reset();
    test_loopback();
    test_free_space();
    test_round_robin();
    test_write_over_read();
    test_backpressure();
    $display("tests run: %0d, errors: %0d", N_TESTS, errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

  // watchdog, 400 cycles per test
  initial
  begin
    #(N_TESTS * 400 * 40);
    $display("watchdog expired before the tests finished, errors so far: %0d", errors);
    $display("TB FAILED");
    $finish;
  end

endmodule

//--- tb.f
verilog/ft_master_pkg.sv
verilog/ep_fifo.sv
verilog/ep_buffer_bank.sv
verilog/ft_arbiter.sv
verilog/ft_bus_fsm.sv
verilog/ft_master_top.sv
test/tb_ft_master.sv

//--- run.sh
#!/bin/sh
# build and run the ft master testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tb_ft_master -o tb_ft_master
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_ft_master)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1
